//--- Bender.yml
package:
  name: pcap_replay_stream

sources:
  - include_dirs:
      - include
    files:
      - hw/replay_pkg.sv
      - hw/replay_word_fifo.sv
      - hw/fifo_to_axis.sv
      - hw/axis_out_slice.sv
      - hw/pcap_replay_stream.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/replay_asserts.sv
      - dv/replay_tb.sv

//--- dv/replay_asserts.sv
// Protocol checks on the replay stream ports, bound into pcap_replay_stream
// fifo_empty is the internal buffer flag of the top level

`timescale 1ns/100ps
`default_nettype none

module replay_asserts (
  input wire                    axi_aclk,
  input wire                    reset,
  input wire                    sw_rst,
  input wire                    full,
  input wire                    fifo_empty,
  input replay_pkg::axis_beat_t m_axis,
  input wire                    m_axis_tvalid,
  input wire                    m_axis_tready
);

  // Running total of failed checks
  int fail_count = 0;

  // Output idle right after either reset
  a_idle_after_reset: assert property (
    @(posedge axi_aclk) (reset || sw_rst) |=> !m_axis_tvalid
  ) else begin
    fail_count++;
    $error("m_axis_tvalid high in the cycle after reset");
  end

  // Stalled beat holds, a flush in that cycle is exempt
  a_hold_when_stalled: assert property (
    @(posedge axi_aclk) disable iff (reset)
    (m_axis_tvalid && !m_axis_tready && !sw_rst) |=> (m_axis_tvalid && $stable(m_axis))
  ) else begin
    fail_count++;
    $error("m_axis changed or dropped tvalid while tready was low");
  end

  // Full can only follow a non-empty buffer
  a_full_not_from_empty: assert property (
    @(posedge axi_aclk) disable iff (reset)
    $rose(full) |-> !$past(fifo_empty)
  ) else begin
    fail_count++;
    $error("full rose while the buffer was empty");
  end

endmodule

bind pcap_replay_stream replay_asserts u_asserts (
  .axi_aclk      (axi_aclk),
  .reset         (reset),
  .sw_rst        (sw_rst),
  .full          (full),
  .fifo_empty    (fifo_empty),
  .m_axis        (m_axis),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready)
);

`default_nettype wire

//--- dv/replay_tb.sv
// Directed tests for the replay stream, expected beats built from the framing rule
// Inputs change on the falling edge, outputs are sampled on the rising edge

`timescale 1ns/100ps
`default_nettype none

`include "replay_config.svh"

module replay_tb;

  import replay_pkg::*;

  localparam int DW = 8 * `REPLAY_LANES;
  localparam int SW = `REPLAY_LANES;
  localparam int UW = `REPLAY_TUSER_WIDTH;
  localparam int WD_CYCLES_PER_WORD = 40;
  localparam int WD_MARGIN = 500;

  logic              axi_aclk;
  logic              reset;
  logic              sw_rst;
  logic              wr_en;
  replay_fifo_word_t din;
  logic              full;
  axis_beat_t        m_axis;
  logic              m_axis_tvalid;
  logic              m_axis_tready;

  // Beats still owed by the DUT, oldest first
  axis_beat_t exp_q[$];

  integer seed;
  string  test_name;
  int     err_count;
  int     words_queued;
  int     beat_count;
  int     last_count;
  int     wd_cycles;
  bit     rand_ready;

  pcap_replay_stream dut0 (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .sw_rst        (sw_rst),
    .wr_en         (wr_en),
    .din           (din),
    .full          (full),
    .m_axis        (m_axis),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

  always #2 axi_aclk = ~axi_aclk;

  // Random back-pressure, only when a test enables it
  always @(negedge axi_aclk) begin
    if (rand_ready) begin
      m_axis_tready = 1'($random(seed));
    end
  end

  task automatic check_value(input string what, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      err_count++;
      $display("Error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  // Each accepted beat against the head of the model queue
  always @(posedge axi_aclk) begin
    axis_beat_t exp_beat;
    if (!reset && m_axis_tvalid && m_axis_tready) begin
      beat_count++;
      if (m_axis.tlast) begin
        last_count++;
      end
      if (exp_q.size() == 0) begin
        err_count++;
        $display("Test %s: the DUT sent a beat that no packet accounts for", test_name);
      end else begin
        exp_beat = exp_q.pop_front();
        check_value("tdata", exp_beat.tdata, m_axis.tdata);
        check_value("tstrb", exp_beat.tstrb, m_axis.tstrb);
        check_value("tuser", exp_beat.tuser, m_axis.tuser);
        check_value("tlast", exp_beat.tlast, m_axis.tlast);
      end
    end
  end

  function automatic logic [DW-1:0] random_data();
    return {$random(seed), $random(seed)};
  endfunction

  // Lane i holds strobe bit i above data byte i
  function automatic replay_fifo_word_t make_entry(input logic [DW-1:0] data,
                                                   input logic [SW-1:0] strb);
    replay_fifo_word_t w;
    for (int i = 0; i < SW; i++) begin
      w[i].strb = strb[i];
      w[i].data = data[8*i +: 8];
    end
    return w;
  endfunction

  // Data entry as it should leave, tlast on any short strobe
  function automatic axis_beat_t model_beat(input logic [DW-1:0] data,
                                            input logic [SW-1:0] strb,
                                            input logic [UW-1:0] tuser);
    axis_beat_t b;
    b.tdata = data;
    b.tstrb = strb;
    b.tuser = tuser;
    b.tlast = (strb != {SW{1'b1}});
    return b;
  endfunction

  task automatic write_entry(input replay_fifo_word_t w);
    while (full) begin
      @(negedge axi_aclk);
    end
    wr_en = 1'b1;
    din   = w;
    words_queued++;
    @(negedge axi_aclk);
    wr_en = 1'b0;
  endtask

  // Header first, then full beats, then one short beat that may be empty
  task automatic send_packet(input logic [UW-1:0] tuser, input int len);
    logic [DW-1:0] data;
    logic [SW-1:0] strb;
    int            rem;
    data = random_data();
    data[UW-1:0] = tuser;
    write_entry(make_entry(data, SW'($random(seed))));
    rem  = len;
    strb = {SW{1'b1}};
    while (strb == {SW{1'b1}}) begin
      data = random_data();
      strb = (rem >= SW) ? {SW{1'b1}} : SW'((1 << rem) - 1);
      exp_q.push_back(model_beat(data, strb, tuser));
      write_entry(make_entry(data, strb));
      rem = rem - SW;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge axi_aclk);
    end
    // Room for a stray extra beat to show up
    repeat (4) @(negedge axi_aclk);
  endtask

  task automatic single_packet();
    int start;
    test_name = "single";
    start = beat_count;
    m_axis_tready = 1'b1;
    send_packet(32'h1234_5678, 13);
    wait_drain();
    check_value("beat count", 2, beat_count - start);
  endtask

  task automatic back_to_back_packets();
    int start_beats;
    int start_lasts;
    test_name = "back_to_back";
    start_beats = beat_count;
    start_lasts = last_count;
    m_axis_tready = 1'b1;
    send_packet(32'hA000_0001, 5);
    send_packet(32'hB000_0002, 16);
    send_packet(32'hC000_0003, 21);
    wait_drain();
    check_value("beat count", 7, beat_count - start_beats);
    check_value("tlast count", 3, last_count - start_lasts);
  endtask

  task automatic random_backpressure();
    test_name = "random_ready";
    rand_ready = 1'b1;
    for (int p = 0; p < 20; p++) begin
      send_packet($random(seed), 1 + ({$random(seed)} % 40));
    end
    wait_drain();
    rand_ready = 1'b0;
    m_axis_tready = 1'b1;
  endtask

  // Stalled output, FIFO plus framer plus slice should fill before 20 words
  task automatic fill_while_stalled();
    logic [DW-1:0] data;
    logic [UW-1:0] tuser;
    int            n;
    bit            saw_full;
    test_name = "fill";
    m_axis_tready = 1'b0;
    saw_full = 1'b0;
    tuser = $random(seed);
    data = random_data();
    data[UW-1:0] = tuser;
    write_entry(make_entry(data, '0));
    n = 1;
    while (!saw_full && n < 20) begin
      if (full) begin
        saw_full = 1'b1;
      end else begin
        data = random_data();
        exp_q.push_back(model_beat(data, {SW{1'b1}}, tuser));
        write_entry(make_entry(data, {SW{1'b1}}));
        n++;
      end
    end
    if (!saw_full) begin
      err_count++;
      $display("Test fill: full did not rise within 20 written words");
    end
    m_axis_tready = 1'b1;
    data = random_data();
    exp_q.push_back(model_beat(data, 8'h07, tuser));
    write_entry(make_entry(data, 8'h07));
    wait_drain();
  endtask

  task automatic flush_mid_packet();
    logic [DW-1:0] data;
    logic [UW-1:0] tuser;
    test_name = "sw_rst";
    m_axis_tready = 1'b0;
    tuser = $random(seed);
    data = random_data();
    data[UW-1:0] = tuser;
    write_entry(make_entry(data, '0));
    for (int i = 0; i < 3; i++) begin
      data = random_data();
      exp_q.push_back(model_beat(data, {SW{1'b1}}, tuser));
      write_entry(make_entry(data, {SW{1'b1}}));
    end
    while (!m_axis_tvalid) begin
      @(negedge axi_aclk);
    end
    sw_rst = 1'b1;
    @(negedge axi_aclk);
    sw_rst = 1'b0;
    // Partial packet is gone
    exp_q.delete();
    check_value("tvalid after sw_rst", 0, m_axis_tvalid);
    m_axis_tready = 1'b1;
    send_packet(32'hCAFE_0005, 11);
    wait_drain();
  endtask

  // Limit grows with every word the tests write
  initial begin
    wd_cycles = 0;
    while (wd_cycles <= WD_CYCLES_PER_WORD * words_queued + WD_MARGIN) begin
      @(posedge axi_aclk);
      wd_cycles++;
    end
    $display("Stream stalled: no progress within %0d cycles in test %s", wd_cycles, test_name);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    axi_aclk      = 1'b0;
    reset         = 1'b1;
    sw_rst        = 1'b0;
    wr_en         = 1'b0;
    din           = '0;
    m_axis_tready = 1'b0;
    rand_ready    = 1'b0;
    seed          = 82204;
    err_count     = 0;
    words_queued  = 0;
    beat_count    = 0;
    last_count    = 0;
    test_name     = "reset";
    repeat (8) @(negedge axi_aclk);
    reset = 1'b0;
    check_value("full after reset", 0, full);
    check_value("tvalid after reset", 0, m_axis_tvalid);
    single_packet();
    back_to_back_packets();
    random_backpressure();
    fill_while_stalled();
    flush_mid_packet();
    $display("Errors: %0d, assertion failures: %0d", err_count, dut0.u_asserts.fail_count);
    if (err_count == 0 && dut0.u_asserts.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/axis_out_slice.sv
// Two-entry registered AXI Stream stage
// Upstream ready comes from occupancy only, never from m_axis_tready

`timescale 1ns/100ps
`default_nettype none

module axis_out_slice (
  input  wire                    axi_aclk,
  input  wire                    reset,
  input  wire                    sw_rst,
  input  replay_pkg::axis_beat_t s_beat,
  input  wire                    s_valid,
  output logic                   s_ready,
  output replay_pkg::axis_beat_t m_axis,
  output logic                   m_axis_tvalid,
  input  wire                    m_axis_tready
);

  import replay_pkg::*;

  // Main drives the output, skid catches the overflow beat
  axis_beat_t main_q;
  axis_beat_t skid_q;

  // Entries held, 0 to 2
  logic [1:0] count;

  logic up_xfer;
  logic dn_xfer;
  logic load_main_in;
  logic load_main_skid;
  logic load_skid;

  assign s_ready       = (count < 2'd2);
  assign m_axis_tvalid = (count != 2'd0);
  assign m_axis        = main_q;

  assign up_xfer = s_valid & s_ready;
  assign dn_xfer = m_axis_tvalid & m_axis_tready;

  // Empty, or single entry leaving as a new one arrives
  assign load_main_in = up_xfer &
                        ((count == 2'd0) || ((count == 2'd1) && dn_xfer));
  // Single entry stuck, new one parks behind it
  assign load_skid = up_xfer && (count == 2'd1) && !dn_xfer;
  // Full and draining, skid moves forward to keep order
  assign load_main_skid = dn_xfer && (count == 2'd2);

  // Occupancy
  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      count <= 2'd0;
    end else begin
      count <= count + {1'b0, up_xfer} - {1'b0, dn_xfer};
    end
  end

  // Payload
  always_ff @(posedge axi_aclk) begin
    if (load_main_in) begin
      main_q <= s_beat;
    end else if (load_main_skid) begin
      main_q <= skid_q;
    end
    if (load_skid) begin
      skid_q <= s_beat;
    end
  end

endmodule

`default_nettype wire

//--- hw/fifo_to_axis.sv
// Packet framer, first entry is metadata, later entries are data beats
// A non-full strobe ends the packet, so 8-byte multiples end on strobe zero
// Output is combinational from the FIFO head

`timescale 1ns/100ps
`default_nettype none

`include "replay_config.svh"

module fifo_to_axis (
  input  wire                           axi_aclk,
  input  wire                           reset,
  input  wire                           sw_rst,
  input  replay_pkg::replay_fifo_word_t fifo_word,
  input  wire                           empty,
  output logic                          rd_en,
  output replay_pkg::axis_beat_t        beat,
  output logic                          valid,
  input  wire                           ready
);

  import replay_pkg::*;

  typedef enum logic {
    ST_HDR  = 1'b0,
    ST_DATA = 1'b1
  } frame_state_t;

  frame_state_t state;
  frame_state_t state_nxt;

  // Registered metadata for the packet in flight
  logic [`REPLAY_TUSER_WIDTH-1:0] tuser_q;
  logic [`REPLAY_TUSER_WIDTH-1:0] tuser_nxt;

  // Unpacked head entry
  replay_data_u              data_u;
  logic [`REPLAY_LANES-1:0] strb;
  logic                      last_beat;

  // Split interleaved lanes into data and strobe
  always_comb begin
    for (int i = 0; i < `REPLAY_LANES; i++) begin
      data_u.beat[8*i +: 8] = fifo_word[i].data;
      strb[i]               = fifo_word[i].strb;
    end
  end

  // Any missing strobe byte terminates
  assign last_beat = ~&strb;

  // Next-state and output decode
  always_comb begin
    state_nxt = state;
    tuser_nxt = tuser_q;
    rd_en     = 1'b0;
    valid     = 1'b0;

    // Beat fields hold steady regardless of ready
    beat.tdata = data_u.beat;
    beat.tstrb = strb;
    beat.tuser = tuser_q;
    beat.tlast = last_beat;

    case (state)
      ST_HDR: begin
        // Header popped without waiting on downstream
        if (!empty) begin
          tuser_nxt = data_u.hdr.tuser;
          rd_en     = 1'b1;
          state_nxt = ST_DATA;
        end
      end

      ST_DATA: begin
        if (!empty) begin
          valid = 1'b1;
          // Pop only on transfer
          if (ready) begin
            rd_en = 1'b1;
            if (last_beat) begin
              state_nxt = ST_HDR;
            end
          end
        end
      end

      default: begin
        state_nxt = ST_HDR;
      end
    endcase
  end

  // State and metadata registers
  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      state   <= ST_HDR;
      tuser_q <= '0;
    end else begin
      state   <= state_nxt;
      tuser_q <= tuser_nxt;
    end
  end

endmodule

`default_nettype wire

//--- hw/pcap_replay_stream.sv
// Stream-out stage of the replay engine, single clock domain
// Write order is preserved end to end, latency varies with buffer fill
// sw_rst drops buffered entries and any partial packet

`timescale 1ns/100ps
`default_nettype none

module pcap_replay_stream (
  input  wire                           axi_aclk,
  input  wire                           reset,
  input  wire                           sw_rst,
  input  wire                           wr_en,
  input  replay_pkg::replay_fifo_word_t din,
  output logic                          full,
  output replay_pkg::axis_beat_t        m_axis,
  output logic                          m_axis_tvalid,
  input  wire                           m_axis_tready
);

  import replay_pkg::*;

  // Buffer head toward framer
  replay_fifo_word_t fifo_word;
  logic              fifo_empty;
  logic              fifo_rd_en;

  // Framer toward output slice
  axis_beat_t frame_beat;
  logic       frame_valid;
  logic       frame_ready;

  replay_word_fifo u_fifo (
    .axi_aclk (axi_aclk),
    .reset    (reset),
    .sw_rst   (sw_rst),
    .wr_en    (wr_en),
    .din      (din),
    .full     (full),
    .rd_en    (fifo_rd_en),
    .dout     (fifo_word),
    .empty    (fifo_empty)
  );

  fifo_to_axis u_framer (
    .axi_aclk  (axi_aclk),
    .reset     (reset),
    .sw_rst    (sw_rst),
    .fifo_word (fifo_word),
    .empty     (fifo_empty),
    .rd_en     (fifo_rd_en),
    .beat      (frame_beat),
    .valid     (frame_valid),
    .ready     (frame_ready)
  );

  axis_out_slice u_slice (
    .axi_aclk      (axi_aclk),
    .reset         (reset),
    .sw_rst        (sw_rst),
    .s_beat        (frame_beat),
    .s_valid       (frame_valid),
    .s_ready       (frame_ready),
    .m_axis        (m_axis),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready)
  );

endmodule

`default_nettype wire

//--- hw/replay_pkg.sv
// Shared types for the replay stream path
// Widths follow replay_config.svh, tuser narrower than tdata

`default_nettype none

`include "replay_config.svh"

package replay_pkg;

  // One lane, strobe above its byte
  typedef struct packed {
    logic       strb;
    logic [7:0] data;
  } replay_lane_t;

  // Interleaved entry, lane 0 sits in bits 8:0
  typedef replay_lane_t [`REPLAY_LANES-1:0] replay_fifo_word_t;

  // Header view of the unpacked data bits
  typedef struct packed {
    logic [8*`REPLAY_LANES-`REPLAY_TUSER_WIDTH-1:0] unused;
    logic [`REPLAY_TUSER_WIDTH-1:0]                 tuser;
  } replay_hdr_t;

  // Same 64 bits, read as header or as raw beat depending on framer state
  typedef union packed {
    logic [8*`REPLAY_LANES-1:0] beat;
    replay_hdr_t                hdr;
  } replay_data_u;

  // AXI Stream beat as carried between framer, slice and outside
  typedef struct packed {
    logic [8*`REPLAY_LANES-1:0]     tdata;
    logic [`REPLAY_LANES-1:0]       tstrb;
    logic [`REPLAY_TUSER_WIDTH-1:0] tuser;
    logic                           tlast;
  } axis_beat_t;

endpackage

`default_nettype wire

//--- hw/replay_word_fifo.sv
// Synchronous FWFT buffer of packed replay entries
// Writes while full are silently dropped, writers must watch full

`timescale 1ns/100ps
`default_nettype none

`include "replay_config.svh"

module replay_word_fifo (
  input  wire                           axi_aclk,
  input  wire                           reset,
  input  wire                           sw_rst,
  input  wire                           wr_en,
  input  replay_pkg::replay_fifo_word_t din,
  output logic                          full,
  input  wire                           rd_en,
  output replay_pkg::replay_fifo_word_t dout,
  output logic                          empty
);

  import replay_pkg::*;

  localparam int AW = $clog2(`REPLAY_FIFO_DEPTH);

  // Entry storage
  replay_fifo_word_t mem [`REPLAY_FIFO_DEPTH];

  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  logic do_wr;
  logic do_rd;

  // Qualified strobes
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  // Flags straight from pointers
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // Head always presented
  assign dout = mem[rd_ptr[AW-1:0]];

  // Pointer update, flush on either reset
  always_ff @(posedge axi_aclk) begin
    if (reset || sw_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Read and write together leave occupancy as is
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Entry store
  always_ff @(posedge axi_aclk) begin
    if (do_wr) begin
      mem[wr_ptr[AW-1:0]] <= din;
    end
  end

endmodule

`default_nettype wire

//--- include/replay_config.svh
// Build-time sizing for the replay stream path
// TUSER width must stay strictly below 8 * lane count
// FIFO depth must be a power of two

`ifndef REPLAY_CONFIG_SVH
`define REPLAY_CONFIG_SVH

// Byte lanes per packed entry
`define REPLAY_LANES 8

// Per-packet metadata carried on tuser
`define REPLAY_TUSER_WIDTH 32

// Buffer entries between writer and framer
`define REPLAY_FIFO_DEPTH 16

`endif

//--- project.f
+incdir+include
hw/replay_pkg.sv
hw/replay_word_fifo.sv
hw/fifo_to_axis.sv
hw/axis_out_slice.sv
hw/pcap_replay_stream.sv
dv/replay_asserts.sv
dv/replay_tb.sv
